//--- rtl/linemult_params.svh
/* build settings for the line doubler, all counted in input pixels or output lines
   BUF_DEPTH_PER_PAGE must equal 2**6 and BUF_NUM_OF_PAGES must equal 2**2 to match
   the counter and page types, and HSTOP must stay below PIXEL_PER_LINE_MAX */

`ifndef LINEMULT_PARAMS_SVH
`define LINEMULT_PARAMS_SVH

////////////////////////////////////////////////////////////
// colour widths
////////////////////////////////////////////////////////////

`define COLOR_WIDTH_I       7
`define COLOR_WIDTH_O       8

////////////////////////////////////////////////////////////
// line buffer
////////////////////////////////////////////////////////////

// a line reaching this many pixels counts as overflowed
`define PIXEL_PER_LINE_MAX  64
`define BUF_NUM_OF_PAGES    4
`define BUF_DEPTH_PER_PAGE  64

////////////////////////////////////////////////////////////
// active window and output sync
////////////////////////////////////////////////////////////

// first active pixel and the pixel just after the last one
`define HSTART              8
`define HSTOP               40

// hsync low width in cycles, vsync low width in output lines
`define HS_WIDTH            4
`define VS_WIDTH            2

// read latency of the buffer, the reader runs ahead by this
`define READ_LEAD           2

`endif

//--- rtl/linemult_pkg.sv
/* shared types of the line doubler
   widths here follow the colour and buffer sizes of linemult_params.svh */

`default_nettype none

package linemult_pkg;

  // single colour components
  typedef logic [6:0] color_i_t;
  typedef logic [7:0] color_o_t;

  // one buffer word, red in the top bits
  typedef struct packed {
    color_i_t r;
    color_i_t g;
    color_i_t b;
  } rgb_i_t;

  // sync word as it travels to the output
  typedef struct packed {
    logic vsync_n;
    logic zero;
    logic hsync_n;
    logic csync_n;
  } sync_t;

  // counters and indices
  typedef logic [5:0]  hcnt_t;
  typedef logic [1:0]  page_t;
  typedef logic [10:0] vcnt_t;

  // scanline strength, 0 keeps the full colour
  typedef logic [3:0]  sl_str_t;

endpackage

`default_nettype wire

//--- rtl/line_writer.sv
/* runs on the input pixel strobe, syncs are sampled only on strobe cycles
   the page counter restarts on a frame edge that meets a line edge, so lines per
   frame must be a multiple of BUF_NUM_OF_PAGES for continuous doubling */

`timescale 1ns/1ps
`default_nettype none

`include "linemult_params.svh"

module line_writer (
  input  wire                         VCLK_Tx,
  input  wire                         nVRST_Tx,
  input  wire                         pix_stb_i,
  input  wire                         vsync_n_i,
  input  wire                         hsync_n_i,
  input  wire linemult_pkg::rgb_i_t   rgb_i,
  output logic                        wr_en_o,
  output linemult_pkg::page_t         wr_page_o,
  output linemult_pkg::hcnt_t         wr_addr_o,
  output linemult_pkg::rgb_i_t        wr_data_o,
  output logic                        new_frame_o,
  output logic                        line_start_o,
  output logic                        line_valid_o,
  output logic                        overflow_o,
  output logic                        arm_o,
  output linemult_pkg::hcnt_t         line_width_o [`BUF_NUM_OF_PAGES]
);
  import linemult_pkg::*;

  localparam hcnt_t HSTART_C = hcnt_t'(`HSTART);
  localparam hcnt_t HSTOP_C  = hcnt_t'(`HSTOP);
  localparam hcnt_t OVF_CNT  = hcnt_t'(`PIXEL_PER_LINE_MAX - 1);

  logic  vs_q;
  logic  hs_q;
  logic  vs_fall;
  logic  hs_fall;
  hcnt_t hcnt;
  page_t page;
  logic  valid_q;
  hcnt_t width_q [`BUF_NUM_OF_PAGES];

  // falling edges, only seen on strobe cycles
  assign vs_fall = pix_stb_i & vs_q & ~vsync_n_i;
  assign hs_fall = pix_stb_i & hs_q & ~hsync_n_i;

  ////////////////////////////////////////////////////////////
  // horizontal count and page rotation
  ////////////////////////////////////////////////////////////

  always_ff @(posedge VCLK_Tx or negedge nVRST_Tx) begin
    if (!nVRST_Tx) begin
      vs_q    <= 1'b0;
      hs_q    <= 1'b0;
      hcnt    <= '0;
      page    <= '0;
      valid_q <= 1'b0;
      for (int i = 0; i < `BUF_NUM_OF_PAGES; i++) begin
        width_q[i] <= '0;
      end
    end else if (pix_stb_i) begin
      vs_q <= vsync_n_i;
      hs_q <= hsync_n_i;
      if (hs_fall) begin
        // close the finished page and move on
        width_q[page] <= hcnt;
        valid_q       <= hcnt > HSTOP_C;
        hcnt          <= '0;
        page          <= vs_fall ? '0 : page + 1'b1;
      end else if (!overflow_o) begin
        hcnt <= hcnt + 1'b1;
      end
    end
  end

  // a line holding 64 pixels sits saturated at index 63
  assign overflow_o = hcnt == OVF_CNT;

  ////////////////////////////////////////////////////////////
  // outputs
  ////////////////////////////////////////////////////////////

  assign wr_en_o   = pix_stb_i & ~hs_fall & (hcnt >= HSTART_C) & (hcnt < HSTOP_C);
  assign wr_page_o = page;
  assign wr_addr_o = hcnt - HSTART_C;
  assign wr_data_o = rgb_i;

  assign new_frame_o  = vs_fall;
  assign line_start_o = hs_fall;
  assign line_valid_o = valid_q;
  // odd field style edge, vsync and hsync fall together
  assign arm_o        = vs_fall & hs_fall;

  assign line_width_o = width_q;

  // the source delivers a pixel on every second cycle at most
  assert property (@(posedge VCLK_Tx) disable iff (!nVRST_Tx) pix_stb_i |=> !pix_stb_i)
    else $error("line_writer: pixel strobe on two cycles in a row");

endmodule

`default_nettype wire

//--- rtl/line_buffer.sv
/* paged two port RAM, one write and one read per cycle
   read data comes back two cycles after rd_en_i and is held while rd_en_i is low */

`timescale 1ns/1ps
`default_nettype none

`include "linemult_params.svh"

module line_buffer (
  input  wire                         VCLK_Tx,
  input  wire                         wr_en_i,
  input  wire linemult_pkg::page_t    wr_page_i,
  input  wire linemult_pkg::hcnt_t    wr_addr_i,
  input  wire linemult_pkg::rgb_i_t   wr_data_i,
  input  wire                         rd_en_i,
  input  wire linemult_pkg::page_t    rd_page_i,
  input  wire linemult_pkg::hcnt_t    rd_addr_i,
  output linemult_pkg::rgb_i_t        rd_data_o
);
  import linemult_pkg::*;

  localparam int WORDS  = `BUF_NUM_OF_PAGES * `BUF_DEPTH_PER_PAGE;
  localparam int ADDR_W = $clog2(WORDS);

  rgb_i_t              mem [WORDS];
  rgb_i_t              rd_q;
  logic [ADDR_W-1:0]   wr_idx;
  logic [ADDR_W-1:0]   rd_idx;

  // page selects the upper address bits
  assign wr_idx = {wr_page_i, wr_addr_i};
  assign rd_idx = {rd_page_i, rd_addr_i};

  always_ff @(posedge VCLK_Tx) begin
    if (wr_en_i) begin
      mem[wr_idx] <= wr_data_i;
    end
    // first stage is the RAM output register
    if (rd_en_i) begin
      rd_q <= mem[rd_idx];
    end
    rd_data_o <= rd_q;
  end

endmodule

`default_nettype wire

//--- rtl/line_reader.sv
/* plays every stored page twice at full clock rate and builds the output sync
   sync_o and draw_sl_o follow the counters directly, in step with data that
   returns from the buffer, and all syncs stay low while the reader is idle */

`timescale 1ns/1ps
`default_nettype none

`include "linemult_params.svh"

module line_reader (
  input  wire                         VCLK_Tx,
  input  wire                         nVRST_Tx,
  input  wire                         linemult_en_i,
  input  wire                         sl_en_i,
  input  wire                         sl_id_i,
  input  wire                         new_frame_i,
  input  wire                         line_start_i,
  input  wire                         line_valid_i,
  input  wire                         overflow_i,
  input  wire                         arm_i,
  input  wire linemult_pkg::page_t    wr_page_i,
  input  wire linemult_pkg::hcnt_t    line_width_i [`BUF_NUM_OF_PAGES],
  output logic                        rd_en_o,
  output linemult_pkg::page_t         rd_page_o,
  output linemult_pkg::hcnt_t         rd_addr_o,
  output logic                        rd_valid_o,
  output logic                        draw_sl_o,
  output linemult_pkg::sync_t         sync_o
);
  import linemult_pkg::*;

  localparam hcnt_t RD_OPEN    = hcnt_t'(`HSTART - `READ_LEAD);
  localparam hcnt_t RD_CLOSE   = hcnt_t'(`HSTOP - `READ_LEAD);
  localparam hcnt_t HS_LEN     = hcnt_t'(`HS_WIDTH);
  localparam vcnt_t VS_LEN     = vcnt_t'(`VS_WIDTH);
  localparam page_t START_PAGE = page_t'(`BUF_NUM_OF_PAGES / 2);
  // output lines since the frame edge at the moment reading starts
  localparam vcnt_t START_VCNT = vcnt_t'(2 * (`BUF_NUM_OF_PAGES / 2 + 1));

  logic                  armed;
  logic                  run;
  logic                  frame_pend;
  logic                  line_start_q;
  logic                  rd_cnt;
  hcnt_t                 hcnt;
  vcnt_t                 vcnt;
  page_t                 page;
  logic                  line_end;
  logic                  stop;
  logic [`READ_LEAD-1:0] valid_pipe;

  assign line_end = hcnt == line_width_i[page];
  // invalid line end is checked once the writer has latched line_valid
  assign stop     = overflow_i | (line_start_q & ~line_valid_i) | ~linemult_en_i;

  ////////////////////////////////////////////////////////////
  // run control and output counters
  ////////////////////////////////////////////////////////////

  always_ff @(posedge VCLK_Tx or negedge nVRST_Tx) begin
    if (!nVRST_Tx) begin
      armed        <= 1'b0;
      run          <= 1'b0;
      frame_pend   <= 1'b0;
      line_start_q <= 1'b0;
      rd_cnt       <= 1'b0;
      hcnt         <= '0;
      vcnt         <= '0;
      page         <= '0;
    end else begin
      line_start_q <= line_start_i;
      if (new_frame_i) begin
        frame_pend <= 1'b1;
      end

      if (run) begin
        if (line_end) begin
          hcnt   <= '0;
          rd_cnt <= ~rd_cnt;
          if (rd_cnt) begin
            page <= page + 1'b1;
          end
          if (frame_pend || new_frame_i) begin
            vcnt       <= '0;
            frame_pend <= 1'b0;
          end else begin
            vcnt <= vcnt + 1'b1;
          end
        end else begin
          hcnt <= hcnt + 1'b1;
        end
      end else if (armed && line_start_i && !new_frame_i && wr_page_i == START_PAGE) begin
        // pages 0 to 2 are complete now
        run        <= 1'b1;
        rd_cnt     <= 1'b0;
        page       <= '0;
        hcnt       <= '0;
        vcnt       <= START_VCNT;
        frame_pend <= 1'b0;
      end

      if (stop) begin
        run   <= 1'b0;
        armed <= 1'b0;
      end
      if (arm_i && linemult_en_i) begin
        armed <= 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // buffer read
  ////////////////////////////////////////////////////////////

  assign rd_en_o   = run & (hcnt >= RD_OPEN) & (hcnt < RD_CLOSE);
  assign rd_page_o = page;
  assign rd_addr_o = hcnt - RD_OPEN;

  always_ff @(posedge VCLK_Tx or negedge nVRST_Tx) begin
    if (!nVRST_Tx) begin
      valid_pipe <= '0;
    end else begin
      valid_pipe <= {valid_pipe[`READ_LEAD-2:0], rd_en_o};
    end
  end

  assign rd_valid_o = valid_pipe[`READ_LEAD-1];

  ////////////////////////////////////////////////////////////
  // sync and scanline flag
  ////////////////////////////////////////////////////////////

  always_comb begin
    sync_o = '0;
    if (run) begin
      sync_o.hsync_n = hcnt >= HS_LEN;
      sync_o.vsync_n = vcnt >= VS_LEN;
      // serrated csync during vsync
      sync_o.csync_n = sync_o.vsync_n ? sync_o.hsync_n : ~sync_o.hsync_n;
    end
  end

  assign draw_sl_o = sl_en_i & (rd_cnt == sl_id_i);

  // writer must stay at least one page away from the page being read
  assert property (@(posedge VCLK_Tx) disable iff (!nVRST_Tx) rd_en_o |-> rd_page_o != wr_page_i)
    else $error("line_reader: read page collides with write page");

endmodule

`default_nettype wire

//--- rtl/scanline_mixer.sv
/* two cycle output stage for doubled video, one cycle in bypass
   scanline darkening scales by (16 - strength) / 16 */

`timescale 1ns/1ps
`default_nettype none

`include "linemult_params.svh"

module scanline_mixer (
  input  wire                         VCLK_Tx,
  input  wire                         nVRST_Tx,
  input  wire                         linemult_en_i,
  input  wire linemult_pkg::sl_str_t  sl_str_i,
  input  wire                         rd_valid_i,
  input  wire                         draw_sl_i,
  input  wire linemult_pkg::sync_t    sync_mult_i,
  input  wire linemult_pkg::rgb_i_t   rgb_buf_i,
  input  wire linemult_pkg::sync_t    bypass_sync_i,
  input  wire linemult_pkg::rgb_i_t   bypass_rgb_i,
  output linemult_pkg::sync_t         sync_o,
  output linemult_pkg::color_o_t      r_o,
  output linemult_pkg::color_o_t      g_o,
  output linemult_pkg::color_o_t      b_o
);
  import linemult_pkg::*;

  sync_t      sync_q;
  logic       sl_q;
  color_o_t   r_q;
  color_o_t   g_q;
  color_o_t   b_q;
  logic [4:0] sl_fac;

  // msb repeat keeps full white at full scale
  function automatic color_o_t widen(input color_i_t c);
    return {c, c[`COLOR_WIDTH_I-1]};
  endfunction

  function automatic color_o_t darken(input color_o_t c, input logic [4:0] f);
    logic [`COLOR_WIDTH_O+4:0] p;
    p = c * f;
    return p[`COLOR_WIDTH_O+3:4];
  endfunction

  assign sl_fac = 5'd16 - {1'b0, sl_str_i};

  always_ff @(posedge VCLK_Tx or negedge nVRST_Tx) begin
    if (!nVRST_Tx) begin
      sync_q <= '0;
      sl_q   <= 1'b0;
      r_q    <= '0;
      g_q    <= '0;
      b_q    <= '0;
      sync_o <= '0;
      r_o    <= '0;
      g_o    <= '0;
      b_o    <= '0;
    end else begin
      // stage 1, blank outside the read window
      sync_q <= sync_mult_i;
      sl_q   <= draw_sl_i;
      r_q    <= rd_valid_i ? widen(rgb_buf_i.r) : '0;
      g_q    <= rd_valid_i ? widen(rgb_buf_i.g) : '0;
      b_q    <= rd_valid_i ? widen(rgb_buf_i.b) : '0;

      // stage 2
      if (!linemult_en_i) begin
        sync_o <= bypass_sync_i;
        r_o    <= widen(bypass_rgb_i.r);
        g_o    <= widen(bypass_rgb_i.g);
        b_o    <= widen(bypass_rgb_i.b);
      end else if (sl_q) begin
        sync_o <= sync_q;
        r_o    <= darken(r_q, sl_fac);
        g_o    <= darken(g_q, sl_fac);
        b_o    <= darken(b_q, sl_fac);
      end else begin
        sync_o <= sync_q;
        r_o    <= r_q;
        g_o    <= g_q;
        b_o    <= b_q;
      end
    end
  end

endmodule

`default_nettype wire

//--- rtl/linemult.sv
/* line doubler top, one clock domain, pixels arrive on pix_stb_i every second cycle
   sl_en_i, sl_id_i and sl_str_i should only change between frames */

`timescale 1ns/1ps
`default_nettype none

`include "linemult_params.svh"

module linemult (
  input  wire                         VCLK_Tx,
  input  wire                         nVRST_Tx,
  input  wire                         pix_stb_i,
  input  wire                         vsync_n_i,
  input  wire                         hsync_n_i,
  input  wire                         csync_n_i,
  input  wire linemult_pkg::color_i_t r_i,
  input  wire linemult_pkg::color_i_t g_i,
  input  wire linemult_pkg::color_i_t b_i,
  input  wire                         linemult_en_i,
  input  wire                         sl_en_i,
  input  wire                         sl_id_i,
  input  wire linemult_pkg::sl_str_t  sl_str_i,
  output linemult_pkg::sync_t         sync_o,
  output linemult_pkg::color_o_t      r_o,
  output linemult_pkg::color_o_t      g_o,
  output linemult_pkg::color_o_t      b_o
);
  import linemult_pkg::*;

  rgb_i_t rgb_in;
  sync_t  bypass_sync;

  // writer side
  logic   wr_en;
  page_t  wr_page;
  hcnt_t  wr_addr;
  rgb_i_t wr_data;
  logic   new_frame;
  logic   line_start;
  logic   line_valid;
  logic   overflow;
  logic   arm;
  hcnt_t  line_width [`BUF_NUM_OF_PAGES];

  // reader side
  logic   rd_en;
  page_t  rd_page;
  hcnt_t  rd_addr;
  rgb_i_t rd_data;
  logic   rd_valid;
  logic   draw_sl;
  sync_t  sync_mult;

  assign rgb_in      = {r_i, g_i, b_i};
  assign bypass_sync = {vsync_n_i, 1'b0, hsync_n_i, csync_n_i};

  line_writer u_line_writer (
    .VCLK_Tx      (VCLK_Tx),
    .nVRST_Tx     (nVRST_Tx),
    .pix_stb_i    (pix_stb_i),
    .vsync_n_i    (vsync_n_i),
    .hsync_n_i    (hsync_n_i),
    .rgb_i        (rgb_in),
    .wr_en_o      (wr_en),
    .wr_page_o    (wr_page),
    .wr_addr_o    (wr_addr),
    .wr_data_o    (wr_data),
    .new_frame_o  (new_frame),
    .line_start_o (line_start),
    .line_valid_o (line_valid),
    .overflow_o   (overflow),
    .arm_o        (arm),
    .line_width_o (line_width)
  );

  line_buffer u_line_buffer (
    .VCLK_Tx   (VCLK_Tx),
    .wr_en_i   (wr_en),
    .wr_page_i (wr_page),
    .wr_addr_i (wr_addr),
    .wr_data_i (wr_data),
    .rd_en_i   (rd_en),
    .rd_page_i (rd_page),
    .rd_addr_i (rd_addr),
    .rd_data_o (rd_data)
  );

  line_reader u_line_reader (
    .VCLK_Tx       (VCLK_Tx),
    .nVRST_Tx      (nVRST_Tx),
    .linemult_en_i (linemult_en_i),
    .sl_en_i       (sl_en_i),
    .sl_id_i       (sl_id_i),
    .new_frame_i   (new_frame),
    .line_start_i  (line_start),
    .line_valid_i  (line_valid),
    .overflow_i    (overflow),
    .arm_i         (arm),
    .wr_page_i     (wr_page),
    .line_width_i  (line_width),
    .rd_en_o       (rd_en),
    .rd_page_o     (rd_page),
    .rd_addr_o     (rd_addr),
    .rd_valid_o    (rd_valid),
    .draw_sl_o     (draw_sl),
    .sync_o        (sync_mult)
  );

  scanline_mixer u_scanline_mixer (
    .VCLK_Tx       (VCLK_Tx),
    .nVRST_Tx      (nVRST_Tx),
    .linemult_en_i (linemult_en_i),
    .sl_str_i      (sl_str_i),
    .rd_valid_i    (rd_valid),
    .draw_sl_i     (draw_sl),
    .sync_mult_i   (sync_mult),
    .rgb_buf_i     (rd_data),
    .bypass_sync_i (bypass_sync),
    .bypass_rgb_i  (rgb_in),
    .sync_o        (sync_o),
    .r_o           (r_o),
    .g_o           (g_o),
    .b_o           (b_o)
  );

endmodule

`default_nettype wire

//--- sim/tb_linemult.sv
/* testbench for the line doubler, frames of 12 lines with 48 input pixels each
   outputs are sampled on the falling clock edge, inputs are driven there too */

`timescale 1ns/1ps
`default_nettype none

`include "linemult_params.svh"

module tb_linemult;
  import linemult_pkg::*;

  localparam int CLK_NS        = 20;
  localparam int LINES         = 12;
  localparam int PIX_PER_LINE  = 48;
  localparam int OVF_PIX       = 70;
  localparam int FRAMES        = 5;
  localparam int FRAME_CYCLES  = LINES * PIX_PER_LINE * 2;
  localparam int RUN_CYCLES    = 10 + 2 * PIX_PER_LINE * 2 + FRAMES * FRAME_CYCLES + OVF_PIX * 2;
  localparam int MARGIN_CYCLES = FRAME_CYCLES;
  localparam int ACTIVE_PIX    = `HSTOP - `HSTART;

  logic     VCLK_Tx;
  logic     nVRST_Tx;
  logic     pix_stb_i;
  logic     vsync_n_i;
  logic     hsync_n_i;
  logic     csync_n_i;
  color_i_t r_i;
  color_i_t g_i;
  color_i_t b_i;
  logic     linemult_en_i;
  logic     sl_en_i;
  logic     sl_id_i;
  sl_str_t  sl_str_i;
  sync_t    sync_o;
  color_o_t r_o;
  color_o_t g_o;
  color_o_t b_o;

  // checker state
  logic        started = 1'b0;
  logic        chk_double = 1'b0;
  logic        ovf_zero = 1'b0;
  logic        byp_q = 1'b0;
  logic [3:0]  exp_sync_q = '0;
  int          exp_r_q;
  int          exp_g_q;
  int          exp_b_q;
  logic        hs_prev = 1'b0;
  logic        in_edge_q = 1'b0;
  logic        hs_last = 1'b0;
  logic        seen_rise = 1'b0;
  logic        edge_armed = 1'b0;
  int          low_cnt = 0;
  int          nz_cnt = 0;
  int          rise_cnt = 0;
  int          out_idx = 0;
  int          exp_r;
  int          exp_g;
  int          exp_b;
  logic [20:0] cur;
  logic [20:0] in_q [$];

  linemult u_linemult (
    .VCLK_Tx       (VCLK_Tx),
    .nVRST_Tx      (nVRST_Tx),
    .pix_stb_i     (pix_stb_i),
    .vsync_n_i     (vsync_n_i),
    .hsync_n_i     (hsync_n_i),
    .csync_n_i     (csync_n_i),
    .r_i           (r_i),
    .g_i           (g_i),
    .b_i           (b_i),
    .linemult_en_i (linemult_en_i),
    .sl_en_i       (sl_en_i),
    .sl_id_i       (sl_id_i),
    .sl_str_i      (sl_str_i),
    .sync_o        (sync_o),
    .r_o           (r_o),
    .g_o           (g_o),
    .b_o           (b_o)
  );

  // 7 to 8 bits, msb copied into the new lsb
  function automatic int widen_ref(input int c);
    return ((c << 1) | (c >> 6)) & 255;
  endfunction

  function automatic int scale_ref(input int c, input int str);
    return (c * (16 - str)) / 16;
  endfunction

  task automatic report_mismatch(input string sig, input int got, input int exp);
    $display("error t=%0t %s got %0h expected %0h", $time, sig, got, exp);
    $display("Some tests failed");
  endtask

  task automatic report_failure(input string msg);
    $display("failure at %0t: %s", $time, msg);
    $display("Some tests failed");
  endtask

  ////////////////////////////////////////////////////////////
  // clock, watchdog
  ////////////////////////////////////////////////////////////

  initial begin
    VCLK_Tx = 1'b0;
    forever begin
      #(CLK_NS / 2) VCLK_Tx = ~VCLK_Tx;
    end
  end

  initial begin
    #((RUN_CYCLES + MARGIN_CYCLES) * CLK_NS);
    report_failure("the run did not finish in time");
    $fatal(1);
  end

  ////////////////////////////////////////////////////////////
  // video source
  ////////////////////////////////////////////////////////////

  task automatic send_pixel(input logic vs_n, input logic hs_n, input logic [20:0] rgb);
    @(negedge VCLK_Tx);
    pix_stb_i = 1'b1;
    vsync_n_i = vs_n;
    hsync_n_i = hs_n;
    csync_n_i = vs_n ? hs_n : ~hs_n;
    {r_i, g_i, b_i} = rgb;
    @(negedge VCLK_Tx);
    pix_stb_i = 1'b0;
  endtask

  task automatic send_line(input logic vs_low, input logic hs_on, input int npix,
                           input logic [20:0] rgb);
    for (int p = 0; p < npix; p++) begin
      send_pixel(~vs_low, ~(hs_on && p < 4), rgb);
    end
  endtask

  // one frame, vsync low on the first two lines, ovf_line gets too many pixels
  task automatic send_frame(input int ovf_line);
    logic [20:0] rgb;
    int          npix;
    for (int l = 0; l < LINES; l++) begin
      rgb[20:14] = 7'($urandom) | 7'h40;
      rgb[13:7]  = 7'($urandom);
      rgb[6:0]   = 7'($urandom);
      npix = (l == ovf_line) ? OVF_PIX : PIX_PER_LINE;
      if (chk_double) begin
        in_q.push_back(rgb);
      end
      // the reader takes over with the fourth line of the first armed frame
      if (l == 3) begin
        started = 1'b1;
      end
      send_line(l < 2, 1'b1, npix, rgb);
      if (l == ovf_line) begin
        ovf_zero = 1'b1;
      end
    end
  endtask

  initial begin
    void'($urandom(32'hf416_8585));
    nVRST_Tx      = 1'b0;
    pix_stb_i     = 1'b0;
    vsync_n_i     = 1'b1;
    hsync_n_i     = 1'b1;
    csync_n_i     = 1'b1;
    r_i           = '0;
    g_i           = '0;
    b_i           = '0;
    linemult_en_i = 1'b1;
    sl_en_i       = 1'b0;
    sl_id_i       = 1'b0;
    sl_str_i      = '0;
    repeat (10) @(negedge VCLK_Tx);
    nVRST_Tx = 1'b1;

    // idle line so the first frame edge is seen and the line counts as valid
    send_line(1'b0, 1'b0, PIX_PER_LINE, '0);

    // plain doubling
    chk_double = 1'b1;
    send_frame(-1);
    send_frame(-1);

    // scanlines on the second line of each pair
    sl_en_i  = 1'b1;
    sl_id_i  = 1'b1;
    sl_str_i = 4'd6;
    send_frame(-1);

    // overflow in line 6
    chk_double = 1'b0;
    in_q.delete();
    send_frame(6);
    ovf_zero = 1'b0;

    // bypass
    linemult_en_i = 1'b0;
    send_frame(-1);
    repeat (8) @(negedge VCLK_Tx);

    $display("All tests passed");
    $finish;
  end

  ////////////////////////////////////////////////////////////
  // checking
  ////////////////////////////////////////////////////////////

  // nothing leaves the DUT before the reader has started
  assert property (@(posedge VCLK_Tx) disable iff (!nVRST_Tx)
                   !started |-> (sync_o == '0 && r_o == '0 && g_o == '0 && b_o == '0))
    else begin
      report_failure("outputs active before the reader started");
      $fatal(1);
    end

  // inputs as the DUT sees them on the same edge
  always @(posedge VCLK_Tx) begin
    byp_q      <= !linemult_en_i;
    exp_sync_q <= {vsync_n_i, 1'b0, hsync_n_i, csync_n_i};
    exp_r_q    <= widen_ref(int'(r_i));
    exp_g_q    <= widen_ref(int'(g_i));
    exp_b_q    <= widen_ref(int'(b_i));
    if (pix_stb_i) begin
      hs_prev <= hsync_n_i;
    end
    in_edge_q <= pix_stb_i & hs_prev & ~hsync_n_i;
  end

  always @(negedge VCLK_Tx) begin
    if (nVRST_Tx) begin
      if (byp_q) begin
        assert (sync_o == exp_sync_q) else begin
          report_mismatch("sync_o", int'(sync_o), int'(exp_sync_q));
          $fatal(1);
        end
        assert (int'(r_o) == exp_r_q && int'(g_o) == exp_g_q && int'(b_o) == exp_b_q)
          else begin
            report_mismatch("rgb_o", int'({r_o, g_o, b_o}),
                            (exp_r_q << 16) | (exp_g_q << 8) | exp_b_q);
            $fatal(1);
          end
      end

      if (ovf_zero) begin
        assert (r_o == '0 && g_o == '0 && b_o == '0) else begin
          report_mismatch("rgb_o", int'({r_o, g_o, b_o}), 0);
          $fatal(1);
        end
      end

      if (chk_double) begin
        if (sync_o.hsync_n && !hs_last) begin
          rise_cnt++;
          if (seen_rise) begin
            assert (low_cnt == `HS_WIDTH) else begin
              report_mismatch("hsync low cycles", low_cnt, `HS_WIDTH);
              $fatal(1);
            end
            assert (nz_cnt == ACTIVE_PIX) else begin
              report_mismatch("active pixels", nz_cnt, ACTIVE_PIX);
              $fatal(1);
            end
          end
          // a new pair starts with the next input line
          if (out_idx % 2 == 0) begin
            assert (in_q.size() > 0) else begin
              report_failure("more output lines than input lines");
              $fatal(1);
            end
            cur = in_q.pop_front();
          end
          exp_r = widen_ref(int'(cur[20:14]));
          exp_g = widen_ref(int'(cur[13:7]));
          exp_b = widen_ref(int'(cur[6:0]));
          if (sl_en_i && (out_idx % 2) == int'(sl_id_i)) begin
            exp_r = scale_ref(exp_r, int'(sl_str_i));
            exp_g = scale_ref(exp_g, int'(sl_str_i));
            exp_b = scale_ref(exp_b, int'(sl_str_i));
          end
          out_idx++;
          nz_cnt    = 0;
          seen_rise = 1'b1;
        end

        if (r_o != '0 || g_o != '0 || b_o != '0) begin
          assert (seen_rise) else begin
            report_failure("colour before the first output line");
            $fatal(1);
          end
          assert (int'(r_o) == exp_r) else begin
            report_mismatch("r_o", int'(r_o), exp_r);
            $fatal(1);
          end
          assert (int'(g_o) == exp_g) else begin
            report_mismatch("g_o", int'(g_o), exp_g);
            $fatal(1);
          end
          assert (int'(b_o) == exp_b) else begin
            report_mismatch("b_o", int'(b_o), exp_b);
            $fatal(1);
          end
          nz_cnt++;
        end

        // two output lines per input line
        if (in_edge_q) begin
          if (edge_armed) begin
            assert (rise_cnt == 2) else begin
              report_mismatch("hsync pulses per input line", rise_cnt, 2);
              $fatal(1);
            end
          end
          rise_cnt   = 0;
          edge_armed = started;
        end
      end else begin
        edge_armed = 1'b0;
      end

      low_cnt = sync_o.hsync_n ? 0 : low_cnt + 1;
      hs_last = sync_o.hsync_n;
    end
  end

endmodule

`default_nettype wire

//--- linemult.f
+incdir+rtl
rtl/linemult_pkg.sv
rtl/line_writer.sv
rtl/line_buffer.sv
rtl/line_reader.sv
rtl/scanline_mixer.sv
rtl/linemult.sv
sim/tb_linemult.sv

//--- run_sim.sh
#!/usr/bin/env bash
# builds the line doubler testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_linemult -Mdir obj_dir -f linemult.f
status=$?
if [ $status -ne 0 ]; then
  echo "build failed with status $status"
  exit 1
fi

./obj_dir/Vtb_linemult
status=$?
if [ $status -ne 0 ]; then
  echo "simulation failed with status $status"
  exit 1
fi

echo "simulation finished"
exit 0
